//--- logic/busPkg.sv
package busPkg;

    // byte address and data word on the CPU data bus
    typedef logic [31:0] busAddrT;
    typedef logic [31:0] busDataT;

    // one enable bit per byte lane, bit 0 is the low byte
    typedef logic [3:0] byteEnT;

    // request driven by the CPU each cycle, strobes are single cycle
    typedef struct packed {
        logic    readEnable;
        logic    writeEnable;
        byteEnT  byteEnable;
        busAddrT address;
        busDataT writeData;
    } busReqT;

    // answer of one peripheral, data is its current read value
    typedef struct packed {
        logic    hit;
        busDataT data;
    } periphRespT;

    // word compare, byte offset bits ignored
    function automatic logic wordMatch(busAddrT addr, busAddrT regAddr);
        return addr[31:2] == regAddr[31:2];
    endfunction

    // lanes with byteEn set take the new byte, the rest keep the old one
    function automatic busDataT mergeBytes(busDataT oldWord, busDataT newWord, byteEnT byteEn);
        busDataT merged;
        merged = oldWord;
        for (int lane = 0; lane < 4; lane++) begin
            if (byteEn[lane]) begin
                merged[8*lane +: 8] = newWord[8*lane +: 8];
            end
        end
        return merged;
    endfunction

endpackage

//--- logic/periphPkg.sv
package periphPkg;

    // memory-mapped register addresses, word aligned
    localparam busPkg::busAddrT stopwatchAddr = 32'hFF20_0510;
    localparam busPkg::busAddrT lfsrAddr      = 32'hFF20_0514;

    // stopwatch count, wraps at 2^32
    typedef logic [31:0] stopwatchCountT;

    // Galois LFSR state, never zero in normal operation
    typedef logic [31:0] lfsrStateT;

    // feedback mask for a right-shifting Galois LFSR
    // taps 32, 22, 2, 1 give a maximal length sequence
    localparam lfsrStateT lfsrTaps = 32'h8020_0003;

    // state after reset, also replaces a zero seed
    localparam lfsrStateT lfsrResetSeed = 32'hACE1_2468;

endpackage

//--- logic/stopwatchTimer.sv
`timescale 1ns/1ps

module stopwatchTimer
    import busPkg::*;
    import periphPkg::*;
#(
    parameter int ticksPerUnit = 50
) (
    input  logic       iCLK,
    input  logic       rstN,
    input  busReqT     busReq,
    output periphRespT resp
);

    // prescaler needs at least one bit even for ticksPerUnit of 1
    localparam int phaseW = (ticksPerUnit > 1) ? $clog2(ticksPerUnit) : 1;

    typedef logic [phaseW-1:0] phaseT;

    // last phase value before the count steps
    localparam phaseT lastPhase = phaseT'(ticksPerUnit - 1);

    logic           swHit;
    logic           swWrite;
    logic           phaseWrap;
    phaseT          phase;
    stopwatchCountT count;
    stopwatchCountT loadValue;

    // address decode on the word address
    assign swHit   = wordMatch(busReq.address, stopwatchAddr);
    assign swWrite = busReq.writeEnable & swHit;

    // prescaler wraps once every ticksPerUnit cycles
    assign phaseWrap = (phase == lastPhase);

    // only enabled lanes of the write change the count
    assign loadValue = mergeBytes(count, busReq.writeData, busReq.byteEnable);

    // prescale phase
    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            phase <= '0;
        end else if (swWrite) begin
            // a load restarts the prescale period
            phase <= '0;
        end else if (phaseWrap) begin
            phase <= '0;
        end else begin
            phase <= phase + phaseT'(1);
        end
    end

    // stopwatch count
    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (swWrite) begin
            count <= loadValue;
        end else if (phaseWrap) begin
            // natural wrap at 2^32
            count <= count + stopwatchCountT'(1);
        end
    end

    // answer is combinational, the merge registers it
    assign resp.hit  = swHit;
    assign resp.data = busDataT'(count);

endmodule

//--- logic/lfsrGenerator.sv
`timescale 1ns/1ps

module lfsrGenerator
    import busPkg::*;
    import periphPkg::*;
(
    input  logic       iCLK,
    input  logic       rstN,
    input  busReqT     busReq,
    output periphRespT resp
);

    logic      lfsrHit;
    logic      lfsrRead;
    logic      lfsrWrite;
    lfsrStateT state;
    lfsrStateT stepped;
    lfsrStateT seedMerged;
    lfsrStateT seedLoad;

    // address decode on the word address
    assign lfsrHit   = wordMatch(busReq.address, lfsrAddr);
    assign lfsrRead  = busReq.readEnable & lfsrHit;
    assign lfsrWrite = busReq.writeEnable & lfsrHit;

    // Galois step, shift right
    // taps folded in when the bit shifted out is one
    always_comb begin
        stepped = state >> 1;
        if (state[0]) begin
            stepped = stepped ^ lfsrTaps;
        end
    end

    // seed merged over the current state, lane by lane
    assign seedMerged = mergeBytes(state, busReq.writeData, busReq.byteEnable);

    // all-zero state would lock up, swap in the reset seed
    assign seedLoad = (seedMerged == '0) ? lfsrResetSeed : seedMerged;

    // state register
    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            state <= lfsrResetSeed;
        end else if (lfsrWrite) begin
            state <= seedLoad;
        end else if (lfsrRead) begin
            // read returns the old state, step at the same edge
            state <= stepped;
        end
    end

    // current state goes out as the read value
    assign resp.hit  = lfsrHit;
    assign resp.data = busDataT'(state);

endmodule

//--- logic/readDataMerge.sv
`timescale 1ns/1ps

module readDataMerge
    import busPkg::*;
(
    input  logic       iCLK,
    input  logic       rstN,
    input  logic       readEnable,
    input  periphRespT swResp,
    input  periphRespT lfsrResp,
    output busDataT    readData
);

    busDataT selData;

    // pick the peripheral that claims the address
    // at most one hits, the address map has no overlap
    always_comb begin
        if (swResp.hit) begin
            selData = swResp.data;
        end else if (lfsrResp.hit) begin
            selData = lfsrResp.data;
        end else begin
            // unmapped address reads as zero
            selData = '0;
        end
    end

    // read data register
    // loads only on a read edge, holds between reads
    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            readData <= '0;
        end else if (readEnable) begin
            readData <= selData;
        end
    end

endmodule

//--- logic/peripheralBus.sv
`timescale 1ns/1ps

module peripheralBus
    import busPkg::*;
#(
    parameter int ticksPerUnit = 50
) (
    input  logic    iCLK,
    input  logic    rstN,
    input  busReqT  busReq,
    output busDataT readData
);

    // per-peripheral answers
    periphRespT swResp;
    periphRespT lfsrResp;

    // stopwatch, prescale set from the top
    stopwatchTimer #(
        .ticksPerUnit(ticksPerUnit)
    ) u_stopwatchTimer (
        .iCLK   (iCLK),
        .rstN   (rstN),
        .busReq (busReq),
        .resp   (swResp)
    );

    // pseudo-random source
    lfsrGenerator u_lfsrGenerator (
        .iCLK   (iCLK),
        .rstN   (rstN),
        .busReq (busReq),
        .resp   (lfsrResp)
    );

    // registered read data back to the CPU
    readDataMerge u_readDataMerge (
        .iCLK       (iCLK),
        .rstN       (rstN),
        .readEnable (busReq.readEnable),
        .swResp     (swResp),
        .lfsrResp   (lfsrResp),
        .readData   (readData)
    );

endmodule

//--- test/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int halfPeriod  = 10,
    parameter int resetCycles = 5
) (
    output logic iCLK,
    output logic rstN
);

    // free-running clock, 20 ns period by default
    initial begin
        iCLK = 1'b0;
        forever #(halfPeriod) iCLK = ~iCLK;
    end

    // reset low over the first cycles, released just after an edge
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge iCLK);
        #1 rstN = 1'b1;
    end

endmodule

//--- test/peripheralBus_chk.sv
`timescale 1ns/1ps

module peripheralBus_chk
    import busPkg::*;
    import periphPkg::*;
#(
    parameter int ticksPerUnit = 50
) (
    input logic    iCLK,
    input logic    rstN,
    input busReqT  busReq,
    input busDataT readData
);

    typedef enum logic [1:0] {readNone, readSw, readLfsr} readKindT;

    int             errorCount;
    logic           swSel;
    logic           lfsrSel;
    logic           readSeen;
    readKindT       lastKind;
    busDataT        expData;
    lfsrStateT      shadowLfsr;
    lfsrStateT      seedMerged;
    stopwatchCountT swBase;
    stopwatchCountT swNow;
    int             swAge;

    // enabled lanes from the new word, others from the old one
    function automatic busDataT mergeLanes(busDataT oldWord, busDataT newWord, byteEnT byteEn);
        busDataT result;
        for (int i = 0; i < 4; i++) begin
            result[8*i +: 8] = byteEn[i] ? newWord[8*i +: 8] : oldWord[8*i +: 8];
        end
        return result;
    endfunction

    // one right shift, taps folded in when a one falls out
    function automatic lfsrStateT nextLfsr(lfsrStateT cur);
        lfsrStateT shifted;
        shifted = cur >> 1;
        return cur[0] ? (shifted ^ lfsrTaps) : shifted;
    endfunction

    initial errorCount = 0;

    // word decode, byte offset ignored
    assign swSel   = busReq.address[31:2] == stopwatchAddr[31:2];
    assign lfsrSel = busReq.address[31:2] == lfsrAddr[31:2];

    // lowest count the stopwatch can show right now
    assign swNow      = swBase + stopwatchCountT'(swAge / ticksPerUnit);
    assign seedMerged = mergeLanes(shadowLfsr, busReq.writeData, busReq.byteEnable);

    // reference models, updated on the same edges as the DUT
    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            shadowLfsr <= lfsrResetSeed;
            swBase     <= '0;
            swAge      <= 0;
            readSeen   <= 1'b0;
            lastKind   <= readNone;
            expData    <= '0;
        end else begin
            // shadow LFSR, zero seed swapped for the reset seed
            if (busReq.writeEnable && lfsrSel) begin
                shadowLfsr <= (seedMerged == '0) ? lfsrResetSeed : seedMerged;
            end else if (busReq.readEnable && lfsrSel) begin
                shadowLfsr <= nextLfsr(shadowLfsr);
            end
            // stopwatch base and cycles since the last load
            if (busReq.writeEnable && swSel) begin
                swBase <= mergeLanes(swNow, busReq.writeData, busReq.byteEnable);
                swAge  <= 0;
            end else begin
                swAge <= swAge + 1;
            end
            // what the next readData should be
            if (busReq.readEnable) begin
                readSeen <= 1'b1;
                if (swSel) begin
                    lastKind <= readSw;
                    expData  <= swNow;
                end else if (lfsrSel) begin
                    lastKind <= readLfsr;
                    expData  <= shadowLfsr;
                end else begin
                    lastKind <= readNone;
                    expData  <= '0;
                end
            end
        end
    end

    // zero until the first read
    resetZero: assert property (@(posedge iCLK) disable iff (!rstN)
        !readSeen |-> readData == '0)
        else begin
            errorCount = errorCount + 1;
            $error("Mismatch readData expected %h actual %h", 32'h0, readData);
        end

    // no read, no change
    holdValue: assert property (@(posedge iCLK) disable iff (!rstN)
        !$past(busReq.readEnable) |-> readData == $past(readData))
        else begin
            errorCount = errorCount + 1;
            $error("Mismatch readData expected %h actual %h", $past(readData), readData);
        end

    // LFSR and unmapped reads are exact
    exactRead: assert property (@(posedge iCLK) disable iff (!rstN)
        $past(busReq.readEnable) && lastKind != readSw |-> readData == expData)
        else begin
            errorCount = errorCount + 1;
            $error("Mismatch readData expected %h actual %h", expData, readData);
        end

    // stopwatch may be one step ahead of the lower bound
    stopwatchRange: assert property (@(posedge iCLK) disable iff (!rstN)
        $past(busReq.readEnable) && lastKind == readSw |-> (readData - expData) <= 32'd1)
        else begin
            errorCount = errorCount + 1;
            $error("Mismatch readData expected %h or %h actual %h",
                   expData, expData + 32'd1, readData);
        end

endmodule

//--- test/peripheralBusTb.sv
`timescale 1ns/1ps

module peripheralBusTb
    import busPkg::*;
    import periphPkg::*;
();

    localparam int unitTicks    = 4;
    localparam int resetTimeout = 50;

    logic    iCLK;
    logic    rstN;
    busReqT  busReq;
    busDataT readData;
    int      timeoutCount;

    clockGen u_clockGen (
        .iCLK (iCLK),
        .rstN (rstN)
    );

    peripheralBus #(
        .ticksPerUnit(unitTicks)
    ) u_peripheralBus (
        .iCLK     (iCLK),
        .rstN     (rstN),
        .busReq   (busReq),
        .readData (readData)
    );

    // reference models and assertions live in the checker
    bind peripheralBus peripheralBus_chk #(
        .ticksPerUnit(ticksPerUnit)
    ) u_chk (
        .iCLK     (iCLK),
        .rstN     (rstN),
        .busReq   (busReq),
        .readData (readData)
    );

    // inputs change 1 ns after the rising edge
    task automatic nextCycle();
        @(posedge iCLK);
        #1;
    endtask

    task automatic idleCycles(int n);
        for (int i = 0; i < n; i++) begin
            nextCycle();
        end
    endtask

    task automatic busWrite(busAddrT addr, busDataT data, byteEnT byteEn);
        busReq             = '0;
        busReq.writeEnable = 1'b1;
        busReq.byteEnable  = byteEn;
        busReq.address     = addr;
        busReq.writeData   = data;
        nextCycle();
        busReq = '0;
    endtask

    task automatic busRead(busAddrT addr);
        busReq            = '0;
        busReq.readEnable = 1'b1;
        busReq.address    = addr;
        nextCycle();
        busReq = '0;
    endtask

    task automatic waitResetRelease();
        int cycles;
        cycles = 0;
        while (rstN !== 1'b1 && cycles < resetTimeout) begin
            @(posedge iCLK);
            cycles++;
        end
        if (rstN !== 1'b1) begin
            timeoutCount++;
            $display("reset still low after %0d cycles", resetTimeout);
        end
        #1;
    endtask

    // push a random address off both registers
    function automatic busAddrT unmappedAddr(busAddrT raw);
        busAddrT addr;
        addr = raw;
        if (addr[31:2] == stopwatchAddr[31:2] || addr[31:2] == lfsrAddr[31:2]) begin
            addr[31] = ~addr[31];
        end
        return addr;
    endfunction

    task automatic runStimulus();
        // idle after reset then the first LFSR read
        idleCycles(3);
        busRead(lfsrAddr);
        idleCycles(2);
        // random seeds and runs of reads with stray low address bits
        for (int s = 0; s < 4; s++) begin
            busWrite(lfsrAddr, $urandom, 4'hF);
            for (int r = 0; r < 6; r++) begin
                busRead(lfsrAddr | ($urandom & 32'h3));
                idleCycles(int'($urandom_range(2, 0)));
            end
        end
        // zero seed as a full word and in one lane
        busWrite(lfsrAddr, 32'h0, 4'hF);
        busRead(lfsrAddr);
        busWrite(lfsrAddr, 32'h0000_00AB, 4'hF);
        busWrite(lfsrAddr, 32'h0, 4'h1);
        busRead(lfsrAddr);
        // stopwatch loads and gaps with a wrap after the first load
        for (int t = 0; t < 6; t++) begin
            busWrite(stopwatchAddr, (t == 0) ? 32'hFFFF_FFFE : $urandom, 4'hF);
            idleCycles((t == 0) ? 12 : int'($urandom_range(20, 0)));
            busRead(stopwatchAddr);
        end
        // partial lanes right after a full load
        for (int p = 0; p < 4; p++) begin
            busWrite(stopwatchAddr, $urandom, 4'hF);
            busWrite(stopwatchAddr, $urandom, byteEnT'($urandom_range(14, 1)));
            busRead(stopwatchAddr);
            busWrite(lfsrAddr, $urandom, 4'hF);
            busWrite(lfsrAddr, $urandom, byteEnT'($urandom_range(14, 1)));
            busRead(lfsrAddr);
        end
        // unmapped reads with idle gaps in between
        for (int u = 0; u < 5; u++) begin
            busRead(unmappedAddr($urandom));
            idleCycles(int'($urandom_range(3, 1)));
        end
        idleCycles(2);
    endtask

    initial begin
        int assertErrors;
        busReq       = '0;
        timeoutCount = 0;
        void'($urandom(32'h1276_2b59));
        waitResetRelease();
        if (timeoutCount == 0) begin
            runStimulus();
        end
        assertErrors = u_peripheralBus.u_chk.errorCount;
        $display("assertion errors %0d, timeouts %0d", assertErrors, timeoutCount);
        if (assertErrors == 0 && timeoutCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
logic/busPkg.sv
logic/periphPkg.sv
logic/stopwatchTimer.sv
logic/lfsrGenerator.sv
logic/readDataMerge.sv
logic/peripheralBus.sv
test/clockGen.sv
test/peripheralBus_chk.sv
test/peripheralBusTb.sv

//--- run.sh
#!/bin/sh
# build and run the peripheral bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module peripheralBusTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# keep running after an assertion error so the summary line is printed
output=$(./obj_dir/VperipheralBusTb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TB PASSED$"; then
    exit 0
fi
exit 1
